//--- src/noc_settings.svh
/*
  Sizing macros for the group request network.
  Included by the packages and by every module that sizes ports.
*/
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Tiles per group and the index width that selects one
`define NOC_NUM_TILES 4
`define NOC_TILE_ID_W 2

// Group coordinate in the mesh
`define NOC_GRP_X_W 2
`define NOC_GRP_Y_W 2

`define NOC_DATA_W 32

// Bank row plus bank select inside one tile
`define NOC_ROW_ADDR_W 10

// Router input buffer entries
`define NOC_FIFO_DEPTH 2

`endif

//--- src/tcdm_pkg.sv
/*
  Memory side types of the remote TCDM request path.
  Shared by the top level and the testbench.
*/
`default_nettype none
`include "noc_settings.svh"

package tcdm_pkg;

  typedef logic [`NOC_GRP_X_W+`NOC_GRP_Y_W-1:0] group_id_t;
  typedef logic [`NOC_TILE_ID_W-1:0] tile_id_t;
  typedef logic [`NOC_ROW_ADDR_W-1:0] row_addr_t;
  typedef logic [`NOC_ROW_ADDR_W+`NOC_TILE_ID_W-1:0] tgt_addr_t;  // Row | bank | tile

  typedef enum logic [1:0] {
    READ    = 2'd0,
    WRITE   = 2'd1,
    AMO_ADD = 2'd2
  } tcdm_op_e;

  typedef struct packed {
    tcdm_op_e                      op;
    logic [`NOC_DATA_W/8-1:0]      be;
    logic [`NOC_DATA_W-1:0]        data;
  } tcdm_payload_t;

  // Issued by a tile towards any group
  typedef struct packed {
    tcdm_payload_t payload;
    group_id_t     tgt_group_id;
    tgt_addr_t     tgt_addr;
  } tcdm_master_req_t;

  // Seen by the target tile, tile bits already stripped
  typedef struct packed {
    tcdm_payload_t payload;
    row_addr_t     tgt_addr;
    tile_id_t      ini_addr;      // Initiator tile, for the reply
    group_id_t     src_group_id;  // Initiator group, for the reply
  } tcdm_slave_req_t;

endpackage

`default_nettype wire

//--- src/noc_flit_pkg.sv
/*
  Network side types: mesh directions, group coordinates and request flits.
  Also holds the round-robin pick shared by the router and the tile crossbar.
*/
`default_nettype none
`include "noc_settings.svh"

package noc_flit_pkg;

  import tcdm_pkg::*;

  localparam int unsigned NUM_DIRS = 5;

  // Doubles as the router port index
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    SOUTH = 3'd3,
    WEST  = 3'd4
  } route_dir_e;

  typedef struct packed {
    logic [`NOC_GRP_X_W-1:0] x;
    logic [`NOC_GRP_Y_W-1:0] y;
  } group_xy_t;

  typedef struct packed {
    group_xy_t src_grp;   // Where a reply would go
    group_xy_t dst_grp;   // Steers the mesh routers
    tile_id_t  src_tile;
    tgt_addr_t tgt_addr;  // Low bits select the target tile
  } req_flit_hdr_t;

  typedef struct packed {
    req_flit_hdr_t hdr;
    tcdm_payload_t payload;
  } req_flit_t;

  // Round-robin pick over up to 8 requesters
  // Search starts just after the last winner, returns -1 when nobody requests
  function automatic int rr_pick(input logic [7:0] req, input int num, input int last);
    int idx;
    int pick;
    pick = -1;
    for (int k = num; k >= 1; k--) begin
      idx = (last + k) % num;
      if (req[idx]) pick = idx;  // Nearest to last+1 is assigned last
    end
    return pick;
  endfunction

endpackage

`default_nettype wire

//--- src/flit_fifo.sv
/*
  Small circular flit buffer with valid/ready on both sides.
  One sits behind every router input port.
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_settings.svh"

module flit_fifo (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  noc_flit_pkg::req_flit_t   in_flit_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  output noc_flit_pkg::req_flit_t   out_flit_o,
  output logic                      out_valid_o,
  input  wire                       out_ready_i
);

  import noc_flit_pkg::*;

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  req_flit_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push, pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_flit_o  = mem[rd_ptr_q];  // Head entry

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= in_flit_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // A flit refused while full must still be offered, unchanged, next cycle
  a_no_write_when_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (in_valid_i && !in_ready_o) |=> (in_valid_i && $stable(in_flit_i)));

endmodule

`default_nettype wire

//--- src/xy_router.sv
/*
  Five-port mesh router with buffered inputs and XY dimension-ordered routing.
  Each output arbitrates round-robin and holds its grant until the flit is taken.
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_settings.svh"

module xy_router (
  input  wire                                                       clk_i,
  input  wire                                                       rst_n_i,
  input  noc_flit_pkg::group_xy_t                                   group_id_i,
  input  noc_flit_pkg::req_flit_t [noc_flit_pkg::NUM_DIRS-1:0]      in_flit_i,
  input  wire                     [noc_flit_pkg::NUM_DIRS-1:0]      in_valid_i,
  output logic                    [noc_flit_pkg::NUM_DIRS-1:0]      in_ready_o,
  output noc_flit_pkg::req_flit_t [noc_flit_pkg::NUM_DIRS-1:0]      out_flit_o,
  output logic                    [noc_flit_pkg::NUM_DIRS-1:0]      out_valid_o,
  input  wire                     [noc_flit_pkg::NUM_DIRS-1:0]      out_ready_i
);

  import noc_flit_pkg::*;

  localparam int PORT_W = $bits(route_dir_e);

  req_flit_t  [NUM_DIRS-1:0]             buf_flit;
  logic       [NUM_DIRS-1:0]             buf_valid, buf_ready;
  route_dir_e                            route [NUM_DIRS];
  logic       [NUM_DIRS-1:0][NUM_DIRS-1:0] req;  // [output][input]

  logic [NUM_DIRS-1:0]             arb_vld;
  logic [NUM_DIRS-1:0][PORT_W-1:0] arb_idx;
  logic [NUM_DIRS-1:0]             lock_q;
  logic [NUM_DIRS-1:0][PORT_W-1:0] lock_idx_q, rr_q;

  function automatic route_dir_e xy_route(input group_xy_t dst, input group_xy_t here);
    route_dir_e dir;
    if (dst.x > here.x)      dir = EAST;   // X first
    else if (dst.x < here.x) dir = WEST;
    else if (dst.y > here.y) dir = NORTH;
    else if (dst.y < here.y) dir = SOUTH;
    else                     dir = LOCAL;
    return dir;
  endfunction

  for (genvar i = 0; i < NUM_DIRS; i++) begin : gen_in_buf
    flit_fifo i_in_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (in_flit_i[i]),
      .in_valid_i  (in_valid_i[i]),
      .in_ready_o  (in_ready_o[i]),
      .out_flit_o  (buf_flit[i]),
      .out_valid_o (buf_valid[i]),
      .out_ready_i (buf_ready[i])
    );

    assign route[i] = xy_route(buf_flit[i].hdr.dst_grp, group_id_i);

    for (genvar o = 0; o < NUM_DIRS; o++) begin : gen_req
      assign req[o][i] = buf_valid[i] && (route[i] == route_dir_e'(o));
    end
  end

  // Locked outputs keep their input, free ones pick a new winner
  always_comb begin
    int pick;
    for (int o = 0; o < NUM_DIRS; o++) begin
      pick = rr_pick(8'(req[o]), NUM_DIRS, int'(rr_q[o]));
      if (lock_q[o]) begin
        arb_vld[o] = 1'b1;
        arb_idx[o] = lock_idx_q[o];
      end else if (pick >= 0) begin
        arb_vld[o] = 1'b1;
        arb_idx[o] = PORT_W'(pick);
      end else begin
        arb_vld[o] = 1'b0;
        arb_idx[o] = '0;
      end
      out_valid_o[o] = arb_vld[o];
      out_flit_o[o]  = buf_flit[arb_idx[o]];
    end
  end

  // Pop the buffer of each input whose flit leaves this cycle
  always_comb begin
    buf_ready = '0;
    for (int o = 0; o < NUM_DIRS; o++) begin
      if (arb_vld[o] && out_ready_i[o]) buf_ready[arb_idx[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q     <= '0;
      lock_idx_q <= '0;
      rr_q       <= '0;
    end else begin
      for (int o = 0; o < NUM_DIRS; o++) begin
        if (arb_vld[o] && out_ready_i[o]) begin
          lock_q[o] <= 1'b0;
          rr_q[o]   <= arb_idx[o];  // Winner drops to lowest priority
        end else if (arb_vld[o]) begin
          lock_q[o]     <= 1'b1;
          lock_idx_q[o] <= arb_idx[o];
        end
      end
    end
  end

  for (genvar o = 0; o < NUM_DIRS; o++) begin : gen_out_chk
    // Stalled output keeps its flit
    a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_o[o] && !out_ready_i[o]) |=> (out_valid_o[o] && $stable(out_flit_o[o])));
  end

  for (genvar i = 0; i < NUM_DIRS; i++) begin : gen_gnt_chk
    logic [NUM_DIRS-1:0] gnt_col;

    always_comb begin
      for (int o = 0; o < NUM_DIRS; o++) begin
        gnt_col[o] = arb_vld[o] && (arb_idx[o] == PORT_W'(i));
      end
    end

    // A buffered flit is never claimed by two outputs at once
    a_single_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_col));
  end

endmodule

`default_nettype wire

//--- src/tile_req_xbar.sv
/*
  Tile crossbar behind the routers' local ports.
  Steers each flit to the tile named by the low address bits, no storage on the path.
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_settings.svh"

module tile_req_xbar (
  input  wire                                          clk_i,
  input  wire                                          rst_n_i,
  input  noc_flit_pkg::req_flit_t [`NOC_NUM_TILES-1:0] in_flit_i,
  input  wire                     [`NOC_NUM_TILES-1:0] in_valid_i,
  output logic                    [`NOC_NUM_TILES-1:0] in_ready_o,
  output noc_flit_pkg::req_flit_t [`NOC_NUM_TILES-1:0] out_flit_o,
  output logic                    [`NOC_NUM_TILES-1:0] out_valid_o,
  input  wire                     [`NOC_NUM_TILES-1:0] out_ready_i
);

  import noc_flit_pkg::*;

  localparam int N     = `NOC_NUM_TILES;
  localparam int IDX_W = `NOC_TILE_ID_W;

  logic [N-1:0][N-1:0]     req;  // [output][input]
  logic [N-1:0]            arb_vld;
  logic [N-1:0][IDX_W-1:0] arb_idx;
  logic [N-1:0]            lock_q;
  logic [N-1:0][IDX_W-1:0] lock_idx_q, rr_q;

  for (genvar i = 0; i < N; i++) begin : gen_decode
    for (genvar o = 0; o < N; o++) begin : gen_req
      assign req[o][i] = in_valid_i[i] && (in_flit_i[i].hdr.tgt_addr[IDX_W-1:0] == IDX_W'(o));
    end
  end

  always_comb begin
    int pick;
    for (int o = 0; o < N; o++) begin
      pick = rr_pick(8'(req[o]), N, int'(rr_q[o]));
      if (lock_q[o]) begin
        arb_vld[o] = 1'b1;
        arb_idx[o] = lock_idx_q[o];
      end else if (pick >= 0) begin
        arb_vld[o] = 1'b1;
        arb_idx[o] = IDX_W'(pick);
      end else begin
        arb_vld[o] = 1'b0;
        arb_idx[o] = '0;
      end
      out_valid_o[o] = arb_vld[o];
      out_flit_o[o]  = in_flit_i[arb_idx[o]];
    end
  end

  // Only the winner sees ready
  always_comb begin
    in_ready_o = '0;
    for (int o = 0; o < N; o++) begin
      if (arb_vld[o] && out_ready_i[o]) in_ready_o[arb_idx[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q     <= '0;
      lock_idx_q <= '0;
      rr_q       <= '0;
    end else begin
      for (int o = 0; o < N; o++) begin
        if (arb_vld[o] && out_ready_i[o]) begin
          lock_q[o] <= 1'b0;
          rr_q[o]   <= arb_idx[o];
        end else if (arb_vld[o]) begin
          lock_q[o]     <= 1'b1;  // Hold until the tile accepts
          lock_idx_q[o] <= arb_idx[o];
        end
      end
    end
  end

  for (genvar o = 0; o < N; o++) begin : gen_out_chk
    // Depends on the router holding its local output while stalled
    a_valid_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (out_valid_o[o] && !out_ready_i[o]) |=> (out_valid_o[o] && $stable(out_flit_o[o])));
  end

endmodule

`default_nettype wire

//--- src/group_req_network.sv
/*
  Request side network attachment of one compute group.
  Packs master requests into flits, routes them per tile and unpacks them for the slaves.
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_settings.svh"

module group_req_network (
  input  wire                                clk_i,
  input  wire                                rst_n_i,
  input  noc_flit_pkg::group_xy_t            group_id_i,
  // Master side, one remote port per tile
  input  tcdm_pkg::tcdm_master_req_t [`NOC_NUM_TILES-1:0] master_req_i,
  input  wire                        [`NOC_NUM_TILES-1:0] master_valid_i,
  output logic                       [`NOC_NUM_TILES-1:0] master_ready_o,
  // Slave side
  output tcdm_pkg::tcdm_slave_req_t  [`NOC_NUM_TILES-1:0] slave_req_o,
  output logic                       [`NOC_NUM_TILES-1:0] slave_valid_o,
  input  wire                        [`NOC_NUM_TILES-1:0] slave_ready_i,
  // Mesh links, indexed by direction then tile
  input  noc_flit_pkg::req_flit_t
    [noc_flit_pkg::WEST:noc_flit_pkg::NORTH][`NOC_NUM_TILES-1:0] mesh_flit_i,
  input  wire
    [noc_flit_pkg::WEST:noc_flit_pkg::NORTH][`NOC_NUM_TILES-1:0] mesh_valid_i,
  output logic
    [noc_flit_pkg::WEST:noc_flit_pkg::NORTH][`NOC_NUM_TILES-1:0] mesh_ready_o,
  output noc_flit_pkg::req_flit_t
    [noc_flit_pkg::WEST:noc_flit_pkg::NORTH][`NOC_NUM_TILES-1:0] mesh_flit_o,
  output logic
    [noc_flit_pkg::WEST:noc_flit_pkg::NORTH][`NOC_NUM_TILES-1:0] mesh_valid_o,
  input  wire
    [noc_flit_pkg::WEST:noc_flit_pkg::NORTH][`NOC_NUM_TILES-1:0] mesh_ready_i
);

  import tcdm_pkg::*;
  import noc_flit_pkg::*;

  localparam int N = `NOC_NUM_TILES;

  // Router side view, indexed by tile then port
  req_flit_t [N-1:0][NUM_DIRS-1:0] rt_in_flit, rt_out_flit;
  logic      [N-1:0][NUM_DIRS-1:0] rt_in_valid, rt_in_ready;
  logic      [N-1:0][NUM_DIRS-1:0] rt_out_valid, rt_out_ready;

  req_flit_t [N-1:0] xbar_in_flit, xbar_out_flit;
  logic      [N-1:0] xbar_in_valid, xbar_in_ready;

  for (genvar t = 0; t < N; t++) begin : gen_tile
    // Master request into a flit
    assign rt_in_flit[t][LOCAL] = '{
      hdr: '{
        src_grp:  group_id_i,
        dst_grp:  group_xy_t'(master_req_i[t].tgt_group_id),
        src_tile: tile_id_t'(t),
        tgt_addr: master_req_i[t].tgt_addr
      },
      payload: master_req_i[t].payload
    };
    assign rt_in_valid[t][LOCAL] = master_valid_i[t];
    assign master_ready_o[t]     = rt_in_ready[t][LOCAL];

    for (genvar d = NORTH; d <= WEST; d++) begin : gen_mesh
      assign rt_in_flit[t][d]   = mesh_flit_i[d][t];
      assign rt_in_valid[t][d]  = mesh_valid_i[d][t];
      assign mesh_ready_o[d][t] = rt_in_ready[t][d];
      assign mesh_flit_o[d][t]  = rt_out_flit[t][d];
      assign mesh_valid_o[d][t] = rt_out_valid[t][d];
      assign rt_out_ready[t][d] = mesh_ready_i[d][t];
    end

    xy_router i_req_router (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .group_id_i  (group_id_i),
      .in_flit_i   (rt_in_flit[t]),
      .in_valid_i  (rt_in_valid[t]),
      .in_ready_o  (rt_in_ready[t]),
      .out_flit_o  (rt_out_flit[t]),
      .out_valid_o (rt_out_valid[t]),
      .out_ready_i (rt_out_ready[t])
    );

    // Local deliveries go through the tile crossbar
    assign xbar_in_flit[t]         = rt_out_flit[t][LOCAL];
    assign xbar_in_valid[t]        = rt_out_valid[t][LOCAL];
    assign rt_out_ready[t][LOCAL]  = xbar_in_ready[t];

    // Flit back into a slave request, tile bits dropped
    assign slave_req_o[t] = '{
      payload:      xbar_out_flit[t].payload,
      tgt_addr:     xbar_out_flit[t].hdr.tgt_addr[`NOC_TILE_ID_W +: `NOC_ROW_ADDR_W],
      ini_addr:     xbar_out_flit[t].hdr.src_tile,
      src_group_id: group_id_t'(xbar_out_flit[t].hdr.src_grp)
    };
  end

  tile_req_xbar i_tile_xbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_flit_i   (xbar_in_flit),
    .in_valid_i  (xbar_in_valid),
    .in_ready_o  (xbar_in_ready),
    .out_flit_o  (xbar_out_flit),
    .out_valid_o (slave_valid_o),
    .out_ready_i (slave_ready_i)
  );

endmodule

`default_nettype wire

//--- testbench/tb_group_req_network.sv
/*
  Table-driven testbench for group_req_network with per-exit scoreboards.
  Two passes over the table: full ready first, then random back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none
`include "noc_settings.svh"

module tb_group_req_network;

  import tcdm_pkg::*;
  import noc_flit_pkg::*;

  localparam int N       = `NOC_NUM_TILES;
  localparam int NUM_EP  = N * NUM_DIRS;  // Index = dir * N + tile, dir 0 is the tile port
  localparam int TBL_LEN = 26;
  localparam int TIMEOUT = TBL_LEN * 2 * 64;

  typedef struct {
    string     name;
    int        ep;
    req_flit_t flit;  // As it looks once packed
  } entry_t;

  logic                     clk_i, rst_n_i;
  group_xy_t                group_id;
  tcdm_master_req_t [N-1:0] master_req;
  logic [N-1:0]             master_valid, master_ready;
  tcdm_slave_req_t  [N-1:0] slave_req;
  logic [N-1:0]             slave_valid, slave_ready;
  req_flit_t [WEST:NORTH][N-1:0] mesh_flit_in, mesh_flit_out;
  logic [WEST:NORTH][N-1:0]      mesh_valid_in, mesh_ready_out, mesh_valid_out, mesh_ready_in;

  entry_t      tbl [TBL_LEN];
  int          tbl_cnt = 0;
  int          exp_q [NUM_EP][$];  // Table indices per exit
  int          pending = 0;
  int          errors = 0;
  int          checks = 0;
  logic        random_ready = 1'b0;
  logic [31:0] rnd_state = 32'd10509;

  group_req_network group_req_network_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .group_id_i (group_id),
    .master_req_i (master_req), .master_valid_i (master_valid),
    .master_ready_o (master_ready),
    .slave_req_o (slave_req), .slave_valid_o (slave_valid), .slave_ready_i (slave_ready),
    .mesh_flit_i (mesh_flit_in), .mesh_valid_i (mesh_valid_in), .mesh_ready_o (mesh_ready_out),
    .mesh_flit_o (mesh_flit_out), .mesh_valid_o (mesh_valid_out), .mesh_ready_i (mesh_ready_in)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // X first, then Y, against this group
  function automatic int xy_dir(input group_xy_t dst);
    if (dst.x > group_id.x) return 2;
    if (dst.x < group_id.x) return 4;
    if (dst.y > group_id.y) return 1;
    if (dst.y < group_id.y) return 3;
    return 0;
  endfunction

  function automatic int exit_of(input int k);
    int d;
    d = xy_dir(tbl[k].flit.hdr.dst_grp);
    if (d == 0) return int'(tbl[k].flit.hdr.tgt_addr[`NOC_TILE_ID_W-1:0]);
    return d * N + tbl[k].ep % N;
  endfunction

  function automatic tcdm_slave_req_t exp_slave(input int k);
    tcdm_slave_req_t s;
    s.payload      = tbl[k].flit.payload;
    s.tgt_addr     = row_addr_t'(tbl[k].flit.hdr.tgt_addr >> `NOC_TILE_ID_W);
    s.ini_addr     = tbl[k].flit.hdr.src_tile;
    s.src_group_id = group_id_t'(tbl[k].flit.hdr.src_grp);
    return s;
  endfunction

  task automatic add_entry(input string name, input int ep, input group_xy_t src,
                           input group_xy_t dst, input logic [9:0] row, input int tile);
    req_flit_t f;
    rnd_state         = xorshift32(rnd_state);
    f.hdr.src_grp     = (ep < N) ? group_id : src;  // Masters stamp their own group
    f.hdr.dst_grp     = dst;
    f.hdr.src_tile    = tile_id_t'(ep % N);
    f.hdr.tgt_addr    = {row, tile_id_t'(tile)};
    f.payload.op      = tcdm_op_e'(2'(tbl_cnt % 3));
    f.payload.be      = 4'hf;
    f.payload.data    = {8'(ep), 8'(tbl_cnt), rnd_state[15:0]};  // Top byte names the source
    tbl[tbl_cnt]      = '{name: name, ep: ep, flit: f};
    tbl_cnt++;
  endtask

  task automatic build_table();
    group_xy_t far;
    far = '{x: 2'd0, y: 2'd3};
    add_entry("own_group", 0, far, group_id, 10'h012, 2);
    add_entry("own_group", 3, far, group_id, 10'h3ff, 0);
    add_entry("xy_east", 1, far, '{x: 2'd2, y: 2'd1}, 10'h021, 1);
    add_entry("xy_west", 2, far, '{x: 2'd0, y: 2'd3}, 10'h022, 2);
    add_entry("xy_north", 3, far, '{x: 2'd1, y: 2'd2}, 10'h023, 3);
    add_entry("xy_south", 0, far, '{x: 2'd1, y: 2'd0}, 10'h024, 0);
    add_entry("mesh_deliver", 1 * N + 1, far, group_id, 10'h031, 3);
    add_entry("mesh_deliver", 3 * N + 0, far, group_id, 10'h032, 1);
    add_entry("mesh_forward", 2 * N + 2, far, '{x: 2'd3, y: 2'd1}, 10'h033, 0);
    add_entry("mesh_forward", 4 * N + 3, far, '{x: 2'd1, y: 2'd3}, 10'h034, 2);
    for (int i = 0; i < 16; i++) begin
      add_entry("burst_same_tile", i % N, far, group_id, 10'(100 + i), 1);
    end
  endtask

  function automatic logic ep_ready(input int ep);
    if (ep < N) return master_ready[ep];
    return mesh_ready_out[ep / N][ep % N];
  endfunction

  task automatic offer(input int ep, input int k, input logic vld);
    int d;
    int t;
    d = ep / N;
    t = ep % N;
    if (d == 0) begin
      master_req[t].payload      = tbl[k].flit.payload;
      master_req[t].tgt_group_id = group_id_t'(tbl[k].flit.hdr.dst_grp);
      master_req[t].tgt_addr     = tbl[k].flit.hdr.tgt_addr;
      master_valid[t]            = vld;
    end else begin
      mesh_flit_in[d][t]  = tbl[k].flit;
      mesh_valid_in[d][t] = vld;
    end
  endtask

  // Offer each entry of this entry point in table order
  task automatic drive_ep(input int ep);
    @(negedge clk_i);
    for (int k = 0; k < tbl_cnt; k++) begin
      if (tbl[k].ep == ep) begin
        offer(ep, k, 1'b1);
        while (!ep_ready(ep)) @(negedge clk_i);
        @(negedge clk_i);  // Taken on the edge just passed
      end
    end
    offer(ep, 0, 1'b0);
  endtask

  task automatic check_slave_req(input string name, input tcdm_slave_req_t exp,
                                 input tcdm_slave_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flit(input string name, input req_flit_t exp, input req_flit_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // First pending entry from the same source must be the one that arrived
  task automatic take_output(input int x);
    int d;
    int t;
    int pos;
    int k;
    logic [31:0] data;
    d    = x / N;
    t    = x % N;
    data = (d == 0) ? slave_req[t].payload.data : mesh_flit_out[d][t].payload.data;
    pos  = -1;
    for (int j = exp_q[x].size() - 1; j >= 0; j--) begin
      if (tbl[exp_q[x][j]].ep == int'(data[31:24])) pos = j;
    end
    if (pos < 0) begin
      errors++;
      $display("Error: exit %0d delivered a request that nobody expected there", x);
    end else begin
      k = exp_q[x][pos];
      exp_q[x].delete(pos);
      pending--;
      if (d == 0) check_slave_req(tbl[k].name, exp_slave(k), slave_req[t]);
      else check_flit(tbl[k].name, tbl[k].flit, mesh_flit_out[d][t]);
    end
  endtask

  initial begin : monitor
    logic [31:0] r1;
    logic [31:0] r2;
    wait (rst_n_i === 1'b1);
    forever begin
      @(negedge clk_i);
      rnd_state = xorshift32(rnd_state);
      r1 = rnd_state;
      rnd_state = xorshift32(rnd_state);
      r2 = rnd_state;
      for (int x = 0; x < NUM_EP; x++) begin
        if (x < N) slave_ready[x] = !random_ready || r1[x] || r2[x];
        else mesh_ready_in[x / N][x % N] = !random_ready || r1[x] || r2[x];
      end
      #1;
      for (int x = 0; x < NUM_EP; x++) begin
        if (x < N && slave_valid[x] && slave_ready[x]) take_output(x);
        if (x >= N && mesh_valid_out[x / N][x % N] && mesh_ready_in[x / N][x % N]) begin
          take_output(x);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT + 8) @(posedge clk_i);
    $display("Error: timeout with %0d requests never delivered", pending);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int left;
    int drain;
    rst_n_i       = 1'b0;
    group_id      = '{x: 2'd1, y: 2'd1};
    master_req    = '0;
    master_valid  = '0;
    slave_ready   = '0;
    mesh_flit_in  = '0;
    mesh_valid_in = '0;
    mesh_ready_in = '0;
    build_table();
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    if (slave_valid !== '0 || mesh_valid_out !== '0) begin
      errors++;
      $display("Error: an output is valid right after reset");
    end
    for (int pass = 0; pass < 2; pass++) begin
      random_ready = (pass == 1);
      for (int k = 0; k < tbl_cnt; k++) begin
        exp_q[exit_of(k)].push_back(k);
        pending++;
      end
      for (int ep = 0; ep < NUM_EP; ep++) begin
        fork
          automatic int ep_c = ep;
          drive_ep(ep_c);
        join_none
      end
      wait fork;
      // Whatever is still queued after the drain window was lost
      drain = 0;
      while (pending != 0 && drain < TBL_LEN * 16) begin
        @(posedge clk_i);
        drain++;
      end
    end
    left = 0;
    for (int x = 0; x < NUM_EP; x++) left += exp_q[x].size();
    if (left != 0) begin
      errors++;
      $display("Error: %0d expected requests were left over", left);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- group_req_network.f
+incdir+src
src/tcdm_pkg.sv
src/noc_flit_pkg.sv
src/flit_fifo.sv
src/xy_router.sv
src/tile_req_xbar.sv
src/group_req_network.sv
testbench/tb_group_req_network.sv

//--- Makefile
# Verilator build and run for the group request network testbench

SRCS := $(wildcard src/*.sv src/*.svh testbench/*.sv)

obj_dir/Vtb_group_req_network: group_req_network.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_group_req_network \
		-f group_req_network.f

.PHONY: run clean

run: obj_dir/Vtb_group_req_network
	./obj_dir/Vtb_group_req_network | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
